//--- i2c_mem.f
verilog/i2c_mem_pkg.sv
verilog/i2c_mem_reg_bank.sv
verilog/i2c_mem_rd_mux.sv
verilog/i2c_mem.sv
sim/tb_clk_gen.sv
sim/tb_i2c_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the i2c_mem testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

ROOT_DIR="$(cd "$(dirname "$0")" && pwd)"
BUILD_DIR="obj_dir"
LOG_FILE="sim.log"
TOP="tb_i2c_mem"

cd "$ROOT_DIR" || { echo "cannot enter $ROOT_DIR"; exit 1; }

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --assert -j 0 \
  --top-module "$TOP" \
  -f i2c_mem.f \
  --Mdir "$BUILD_DIR"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -q "TEST PASSED" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG_FILE"
exit 1

//--- sim/tb_clk_gen.sv
// Free-running testbench clock with a 50% duty cycle, starting low.
// PERIOD_NS should be even so that both halves are whole nanoseconds.

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- sim/tb_i2c_mem.sv
// Testbench for the I2C slave register memory with all four banks built.
// A byte-level reference model tracks the 32 registers; concurrent assertions
// compare rf_data and rd_data with it on every rising edge.
// Inputs change on the falling edge only.

`timescale 1ns/1ns

module tb_i2c_mem;

  localparam int DATA_W      = i2c_mem_pkg::DATA_W;
  localparam int NUM_REGS    = i2c_mem_pkg::NUM_REGS;
  localparam int STATUS_BASE = i2c_mem_pkg::STATUS_BASE;
  localparam int NUM_INIT    = i2c_mem_pkg::NUM_REGS + i2c_mem_pkg::NUM_STATUS;
  localparam int CLK_NS      = 4;

  // Cycle budget per test
  localparam int RST_CYC    = 5;
  localparam int T1_CYC     = 34;
  localparam int T2_CYC     = 200;
  localparam int T3_CYC     = 200;
  localparam int T4_CYC     = 32;
  localparam int T5_CYC     = 48;
  localparam int TAIL_CYC   = 4;
  localparam int TOTAL_CYC  = RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + TAIL_CYC;
  localparam int TIMEOUT_NS = TOTAL_CYC * CLK_NS * 3 / 2;

  logic               wr_clk;
  logic               rst;
  logic               wr_en;
  i2c_mem_pkg::addr_t wr_addr;
  i2c_mem_pkg::addr_t rd_addr;
  i2c_mem_pkg::data_t wr_data;
  i2c_mem_pkg::data_t rd_data;
  i2c_mem_pkg::data_t rf_init [NUM_INIT];
  i2c_mem_pkg::data_t rf_laen [NUM_REGS];
  i2c_mem_pkg::data_t rf_data [NUM_REGS];

  i2c_mem_pkg::data_t model [NUM_REGS];
  logic               model_vld = 1'b0;
  i2c_mem_pkg::data_t exp_rd;
  string              test_name = "idle";

  tb_clk_gen #(
    .PERIOD_NS (CLK_NS)
  ) i_clk_gen (
    .clk (wr_clk)
  );

  i2c_mem #(
    .NUM_BANKS (i2c_mem_pkg::NUM_BANKS)
  ) i_dut (
    .wr_clk  (wr_clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_data (wr_data),
    .rf_init (rf_init),
    .rf_laen (rf_laen),
    .rd_data (rd_data),
    .rf_data (rf_data)
  );

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on failure");
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Write first, then masked bits are overridden by init
  always @(posedge wr_clk)
  begin : model_update
    i2c_mem_pkg::data_t nxt;
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        model[i] <= rf_init[i];
      model_vld <= 1'b1;
    end
    else
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        nxt = model[i];
        if (wr_en && int'(wr_addr) == i)
          nxt = wr_data;
        for (int b = 0; b < DATA_W; b++)
          if (rf_laen[i][b])
            nxt[b] = rf_init[i][b];
        model[i] <= nxt;
      end
    end
  end

  // Expected read byte from the address map
  always_comb
  begin
    if (int'(rd_addr) < NUM_REGS)
      exp_rd = model[rd_addr[4:0]];
    else if (int'(rd_addr) == STATUS_BASE)
      exp_rd = rf_init[STATUS_BASE];
    else if (int'(rd_addr) == STATUS_BASE + 1)
      exp_rd = rf_init[STATUS_BASE + 1];
    else
      exp_rd = '0;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_REGS; i++)
  begin : g_chk
    a_rf_data: assert property (@(posedge wr_clk) model_vld |-> (rf_data[i] == model[i]))
    else stop_with_failure($sformatf("error %s rf_data[%0d] expected %h actual %h",
                                     test_name, i, $sampled(model[i]), $sampled(rf_data[i])));
  end

  a_rd_data: assert property (@(posedge wr_clk) model_vld |-> (rd_data == exp_rd))
  else stop_with_failure($sformatf("error %s rd_data at %0d expected %h actual %h",
                                   test_name, $sampled(rd_addr), $sampled(exp_rd),
                                   $sampled(rd_data)));

  initial
  begin
    #(TIMEOUT_NS);
    stop_with_failure($sformatf("Watchdog expired after %0d ns, the tests did not finish",
                                TIMEOUT_NS));
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic reset_and_read_all();
    test_name = "reset_read";
    for (int i = 0; i < NUM_INIT; i++)
      rf_init[i] = i2c_mem_pkg::data_t'($urandom);
    rst = 1'b1;
    repeat (RST_CYC) @(negedge wr_clk);
    rst = 1'b0;
    for (int a = 0; a < T1_CYC; a++)
    begin
      rd_addr = i2c_mem_pkg::addr_t'(a % NUM_REGS);
      @(negedge wr_clk);
    end
  endtask

  // Read back the previous write address one cycle later
  task automatic random_plain_writes();
    i2c_mem_pkg::addr_t last_addr;
    test_name = "plain_writes";
    last_addr = '0;
    for (int c = 0; c < T2_CYC; c++)
    begin
      wr_en   = ($urandom % 4) != 0;
      wr_addr = i2c_mem_pkg::addr_t'($urandom_range(NUM_REGS - 1, 0));
      wr_data = i2c_mem_pkg::data_t'($urandom);
      rd_addr = last_addr;
      last_addr = wr_addr;
      @(negedge wr_clk);
    end
    wr_en = 1'b0;
  endtask

  task automatic masked_load_writes();
    test_name = "mask_load";
    for (int c = 0; c < T3_CYC; c++)
    begin
      if (c % 8 == 0)
        for (int i = 0; i < NUM_REGS; i++)
          rf_laen[i] = i2c_mem_pkg::data_t'($urandom);
      for (int i = 0; i < NUM_REGS; i++)
        if ($urandom % 4 == 0)
          rf_init[i] = i2c_mem_pkg::data_t'($urandom);
      wr_en   = ($urandom % 8) != 0;
      wr_addr = i2c_mem_pkg::addr_t'($urandom_range(NUM_REGS - 1, 0));
      wr_data = i2c_mem_pkg::data_t'($urandom);
      rd_addr = i2c_mem_pkg::addr_t'($urandom_range(NUM_REGS - 1, 0));
      @(negedge wr_clk);
    end
    wr_en = 1'b0;
    for (int i = 0; i < NUM_REGS; i++)
      rf_laen[i] = '0;
  endtask

  // Sweep 32..63 while the status inits keep moving
  task automatic sweep_status_reads();
    test_name = "status_reads";
    for (int c = 0; c < T4_CYC; c++)
    begin
      rd_addr = i2c_mem_pkg::addr_t'(STATUS_BASE + c);
      rf_init[STATUS_BASE]     = i2c_mem_pkg::data_t'($urandom);
      rf_init[STATUS_BASE + 1] = i2c_mem_pkg::data_t'($urandom);
      @(negedge wr_clk);
    end
  endtask

  task automatic unmapped_address_writes();
    test_name = "unmapped_writes";
    for (int c = 0; c < T5_CYC; c++)
    begin
      wr_en   = 1'b1;
      wr_addr = i2c_mem_pkg::addr_t'($urandom_range(63, NUM_REGS));
      wr_data = i2c_mem_pkg::data_t'($urandom);
      rd_addr = i2c_mem_pkg::addr_t'($urandom_range(63, 0));
      @(negedge wr_clk);
    end
    wr_en = 1'b0;
  endtask

  initial
  begin
    void'($urandom(14));
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    rd_addr = '0;
    wr_data = '0;
    for (int i = 0; i < NUM_INIT; i++)
      rf_init[i] = '0;
    for (int i = 0; i < NUM_REGS; i++)
      rf_laen[i] = '0;

    reset_and_read_all();
    random_plain_writes();
    masked_load_writes();
    sweep_status_reads();
    unmapped_address_writes();

    // Let the last edges be checked
    repeat (TAIL_CYC) @(negedge wr_clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- verilog/i2c_mem.sv
// Register memory behind an I2C slave: 32 writable bytes in banks of eight,
// two read-only status bytes fed from rf_init[32..33], one write port, one
// combinational read port and every register also presented on rf_data.
// Writes land one cycle after the edge. Banks absent when NUM_BANKS < 4 read
// zero and drive zero on their rf_data slice.

`timescale 1ns/1ns

module i2c_mem #(
  parameter int NUM_BANKS = i2c_mem_pkg::NUM_BANKS
) (
  input  logic               wr_clk,
  input  logic               rst,
  input  logic               wr_en,
  input  i2c_mem_pkg::addr_t wr_addr,
  input  i2c_mem_pkg::addr_t rd_addr,
  input  i2c_mem_pkg::data_t wr_data,
  input  i2c_mem_pkg::data_t rf_init [i2c_mem_pkg::NUM_REGS + i2c_mem_pkg::NUM_STATUS],
  input  i2c_mem_pkg::data_t rf_laen [i2c_mem_pkg::NUM_REGS],
  output i2c_mem_pkg::data_t rd_data,
  output i2c_mem_pkg::data_t rf_data [i2c_mem_pkg::NUM_REGS]
);

  localparam int RPB = i2c_mem_pkg::REGS_PER_BANK;

  i2c_mem_pkg::data_t bank_rd [NUM_BANKS];
  i2c_mem_pkg::data_t status_init [i2c_mem_pkg::NUM_STATUS];

  //////////////////////////////////////////////////
  // Status bytes
  //////////////////////////////////////////////////

  // Taken straight from the tail of the init array
  for (genvar s = 0; s < i2c_mem_pkg::NUM_STATUS; s++)
  begin : g_status
    assign status_init[s] = rf_init[i2c_mem_pkg::STATUS_BASE + s];
  end

  //////////////////////////////////////////////////
  // Register banks
  //////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_BANKS; g++)
  begin : g_bank
    i2c_mem_pkg::data_t bank_init [RPB];
    i2c_mem_pkg::data_t bank_laen [RPB];
    i2c_mem_pkg::data_t bank_data [RPB];

    for (genvar r = 0; r < RPB; r++)
    begin : g_slice
      assign bank_init[r]         = rf_init[g * RPB + r];
      assign bank_laen[r]         = rf_laen[g * RPB + r];
      assign rf_data[g * RPB + r] = bank_data[r];
    end

    i2c_mem_reg_bank #(
      .BANK_ID (g)
    ) i_bank (
      .wr_clk       (wr_clk),
      .rst          (rst),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .rd_addr      (rd_addr),
      .wr_data      (wr_data),
      .rf_init      (bank_init),
      .rf_laen      (bank_laen),
      .rf_data      (bank_data),
      .bank_rd_data (bank_rd[g])
    );
  end

  // Unbuilt banks
  for (genvar g = NUM_BANKS; g < i2c_mem_pkg::NUM_BANKS; g++)
  begin : g_absent
    for (genvar r = 0; r < RPB; r++)
    begin : g_zero
      assign rf_data[g * RPB + r] = '0;
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  i2c_mem_rd_mux #(
    .NUM_BANKS (NUM_BANKS)
  ) i_rd_mux (
    .rd_addr      (rd_addr),
    .bank_rd_data (bank_rd),
    .status       (status_init),
    .rd_data      (rd_data)
  );

endmodule

//--- verilog/i2c_mem_pkg.sv
// Widths, counts and address map of the I2C slave register memory.
// The map is fixed: 32 writable bytes at 0..31, two status bytes at 32 and 33,
// and every other address reads zero and ignores writes.
// Addresses are 6 bits, so the map cannot grow past 64 entries.

package i2c_mem_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int DATA_W = 8;
  localparam int ADDR_W = 6;

  //////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////

  // Eight per bank, so the low 3 address bits pick the register
  localparam int REGS_PER_BANK = 8;
  localparam int NUM_BANKS     = 4;
  localparam int NUM_REGS      = NUM_BANKS * REGS_PER_BANK;

  // Read-only status bytes sit right after the writable range
  localparam int STATUS_BASE = 32;
  localparam int NUM_STATUS  = 2;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- verilog/i2c_mem_rd_mux.sv
// Read path of the I2C slave memory, purely combinational.
// Bank bytes below NUM_BANKS*8, status inputs at 32 and 33, zero elsewhere.
// NUM_BANKS may be 1 to 4; the address map itself does not move.

`timescale 1ns/1ns

module i2c_mem_rd_mux #(
  parameter int NUM_BANKS = i2c_mem_pkg::NUM_BANKS
) (
  input  i2c_mem_pkg::addr_t rd_addr,
  input  i2c_mem_pkg::data_t bank_rd_data [NUM_BANKS],
  input  i2c_mem_pkg::data_t status [i2c_mem_pkg::NUM_STATUS],
  output i2c_mem_pkg::data_t rd_data
);

  localparam int IDX_W      = $clog2(i2c_mem_pkg::REGS_PER_BANK);
  localparam int BANK_IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
  localparam int ST_IDX_W   = (i2c_mem_pkg::NUM_STATUS > 1) ?
                              $clog2(i2c_mem_pkg::NUM_STATUS) : 1;
  localparam int BANK_END   = NUM_BANKS * i2c_mem_pkg::REGS_PER_BANK;
  localparam int STATUS_END = i2c_mem_pkg::STATUS_BASE + i2c_mem_pkg::NUM_STATUS;

  logic                    in_bank;
  logic                    in_status;
  logic [BANK_IDX_W-1:0]   bank_sel;
  i2c_mem_pkg::addr_t      st_off;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign in_bank   = rd_addr < i2c_mem_pkg::addr_t'(BANK_END);
  assign in_status = (rd_addr >= i2c_mem_pkg::addr_t'(i2c_mem_pkg::STATUS_BASE)) &&
                     (rd_addr <  i2c_mem_pkg::addr_t'(STATUS_END));

  // Bank number sits just above the register index
  assign bank_sel = rd_addr[IDX_W +: BANK_IDX_W];
  assign st_off   = rd_addr - i2c_mem_pkg::addr_t'(i2c_mem_pkg::STATUS_BASE);

  //////////////////////////////////////////////////
  // Output select
  //////////////////////////////////////////////////

  always_comb
  begin
    if (in_bank)
      rd_data = bank_rd_data[bank_sel];
    else if (in_status)
      rd_data = status[st_off[ST_IDX_W-1:0]];
    else
      rd_data = '0;
  end

endmodule

//--- verilog/i2c_mem_reg_bank.sv
// One bank of eight byte registers for the I2C slave memory.
// BANK_ID must be below the package bank count so that its addresses stay under 32.
// A set load-enable bit forces the init bit every cycle and beats a bus write.
// Synchronous reset loads every register from its init value.

`timescale 1ns/1ns

module i2c_mem_reg_bank #(
  parameter int BANK_ID = 0
) (
  input  logic               wr_clk,
  input  logic               rst,
  input  logic               wr_en,
  input  i2c_mem_pkg::addr_t wr_addr,
  input  i2c_mem_pkg::addr_t rd_addr,
  input  i2c_mem_pkg::data_t wr_data,
  input  i2c_mem_pkg::data_t rf_init [i2c_mem_pkg::REGS_PER_BANK],
  input  i2c_mem_pkg::data_t rf_laen [i2c_mem_pkg::REGS_PER_BANK],
  output i2c_mem_pkg::data_t rf_data [i2c_mem_pkg::REGS_PER_BANK],
  output i2c_mem_pkg::data_t bank_rd_data
);

  localparam int NUM_R = i2c_mem_pkg::REGS_PER_BANK;
  localparam int IDX_W = $clog2(NUM_R);
  localparam int SEL_W = i2c_mem_pkg::ADDR_W - IDX_W;

  logic               bank_hit;
  logic [IDX_W-1:0]   wr_idx;
  logic [IDX_W-1:0]   rd_idx;
  logic [NUM_R-1:0]   reg_wr;
  i2c_mem_pkg::data_t wr_val [NUM_R];

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  // Upper address bits select the bank, only inside the writable range
  assign bank_hit = (wr_addr < i2c_mem_pkg::addr_t'(i2c_mem_pkg::NUM_REGS)) &&
                    (wr_addr[i2c_mem_pkg::ADDR_W-1:IDX_W] == SEL_W'(BANK_ID));

  assign wr_idx = wr_addr[IDX_W-1:0];
  assign rd_idx = rd_addr[IDX_W-1:0];

  always_comb
  begin
    for (int r = 0; r < NUM_R; r++)
    begin
      reg_wr[r] = wr_en && bank_hit && (wr_idx == IDX_W'(r));
      wr_val[r] = reg_wr[r] ? wr_data : rf_data[r];
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  // Masked bits copy init, the rest take the write or hold
  always_ff @(posedge wr_clk)
  begin
    for (int r = 0; r < NUM_R; r++)
    begin
      if (rst)
        rf_data[r] <= rf_init[r];
      else
        rf_data[r] <= (rf_init[r] & rf_laen[r]) | (wr_val[r] & ~rf_laen[r]);
    end
  end

  // Local read port, the top picks between banks
  assign bank_rd_data = rf_data[rd_idx];

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Bus address of each register compared directly, independent of the decode above
  for (genvar r = 0; r < NUM_R; r++)
  begin : g_chk
    localparam i2c_mem_pkg::addr_t REG_ADDR =
      i2c_mem_pkg::addr_t'(BANK_ID * NUM_R + r);

    a_wr_lands: assert property (
      @(posedge wr_clk)
      (!rst && wr_en && (wr_addr == REG_ADDR)) |=>
        (((rf_data[r] ^ $past(wr_data)) & ~$past(rf_laen[r])) == '0)
    )
    else $error("bank %0d reg %0d lost unmasked write bits", BANK_ID, r);
  end

endmodule
